// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_nack_top
RTL_TOP  = nack_top
FILELIST = vlog.f

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// File: hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [7:0]  csr_addr_t;   // byte address
    typedef logic [31:0] csr_data_t;

    // register map, byte offsets
    localparam csr_addr_t ADDR_SCRATCH      = 8'h00;
    localparam csr_addr_t ADDR_CLEAR        = 8'h04;
    localparam csr_addr_t ADDR_JUMP_THRESH  = 8'h08;
    localparam csr_addr_t ADDR_IN_COUNT     = 8'h0C;
    localparam csr_addr_t ADDR_OUT_COUNT    = 8'h10;
    localparam csr_addr_t ADDR_RESYNC_COUNT = 8'h14;
    localparam csr_addr_t ADDR_FLOW_BASE    = 8'h40;   // 16 words, one per flow

    localparam csr_data_t SCRATCH_RESET     = 32'h5566_7788;
    localparam csr_data_t JUMP_THRESH_RESET = 32'd20;

    // wishbone classic request and response
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        csr_addr_t addr;
        csr_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        csr_data_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regs import nack_pkg::*, csr_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire wb_req_t   i_wb,
    output wb_rsp_t        o_wb,
    input  wire            i_in_fire,
    input  wire            i_out_last_fire,
    input  wire            i_resync_pulse,
    output pkt_num_t       o_jump_thresh,
    output flow_sel_t      o_rd_flow,
    input  wire pkt_num_t  i_rd_expected
);

    csr_data_t scratch;
    pkt_num_t  jump_thresh;
    csr_data_t in_count;
    csr_data_t out_count;
    csr_data_t resync_count;
    csr_data_t rd_data;
    logic      ack;
    logic      wb_hit;                                 // new access, ack not yet given
    logic      wr_en;
    logic      clr;
    logic      flow_hit;

    assign wb_hit   = i_wb.cyc && i_wb.stb && !ack;
    assign wr_en    = wb_hit && i_wb.we;
    assign clr      = wr_en && (i_wb.addr == ADDR_CLEAR) && i_wb.dat[0];   // one-cycle strobe
    assign flow_hit = (i_wb.addr[7:6] == ADDR_FLOW_BASE[7:6]);             // 0x40..0x7c

    assign o_rd_flow     = i_wb.addr[5:2];             // word index into flow table
    assign o_jump_thresh = jump_thresh;
    assign o_wb.ack      = ack;
    assign o_wb.dat      = rd_data;

    // ------------------------------------------------------------
    // control registers and ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack         <= 1'b0;
            scratch     <= SCRATCH_RESET;
            jump_thresh <= JUMP_THRESH_RESET;
        end else begin
            ack <= wb_hit;                             // single-cycle ack, every address
            if (wr_en) begin
                case (i_wb.addr)
                    ADDR_SCRATCH:     scratch     <= i_wb.dat;
                    ADDR_JUMP_THRESH: jump_thresh <= i_wb.dat;
                    default:          ;                // read-only or unmapped
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // event counters, clear wins over a same-cycle event
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_count     <= '0;
            out_count    <= '0;
            resync_count <= '0;
        end else if (clr) begin
            in_count     <= '0;
            out_count    <= '0;
            resync_count <= '0;
        end else begin
            if (i_in_fire)       in_count     <= in_count + 1'b1;
            if (i_out_last_fire) out_count    <= out_count + 1'b1;
            if (i_resync_pulse)  resync_count <= resync_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_hit) begin
            if (flow_hit) begin
                rd_data <= i_rd_expected;
            end else begin
                case (i_wb.addr)
                    ADDR_SCRATCH:      rd_data <= scratch;
                    ADDR_JUMP_THRESH:  rd_data <= jump_thresh;
                    ADDR_IN_COUNT:     rd_data <= in_count;
                    ADDR_OUT_COUNT:    rd_data <= out_count;
                    ADDR_RESYNC_COUNT: rd_data <= resync_count;
                    default:           rd_data <= '0;   // clear and unmapped read 0
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/nack_deparser.sv
`timescale 1ns/1ps
`default_nettype none

module nack_deparser import nack_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire nack_rec_t i_rec,
    input  wire            i_rec_valid,
    output logic           o_rec_pop,
    output nack_beat_t     o_beat,
    output logic           o_beat_valid,
    input  wire            i_beat_ready
);

    typedef enum logic {IDLE, SEND} dep_state_e;

    dep_state_e state;
    nack_rec_t  rec_q;                                 // record being sent
    beat_idx_t  beat_idx;

    assign o_rec_pop    = (state == IDLE) && i_rec_valid;
    assign o_beat_valid = (state == SEND);

    // beat order: npn, bitmap, info hi, info lo
    always_comb begin
        case (beat_idx)
            2'd0:    o_beat.data = rec_q.npn;
            2'd1:    o_beat.data = rec_q.bitmap;
            2'd2:    o_beat.data = rec_q.info[INFO_W-1:BEAT_W];
            default: o_beat.data = rec_q.info[BEAT_W-1:0];
        endcase
        o_beat.last = (beat_idx == beat_idx_t'(BEATS_PER_NACK - 1));
    end

    always_ff @(posedge clk) begin
        if (o_rec_pop) rec_q <= i_rec;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            beat_idx <= '0;
        end else begin
            case (state)
                IDLE: if (i_rec_valid) state <= SEND;
                SEND: if (i_beat_ready) begin
                    beat_idx <= beat_idx + 1'b1;       // wraps to 0 after last
                    if (o_beat.last) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_beat_hold: assert property (@(posedge clk) disable iff (rst)
        o_beat_valid && !i_beat_ready |=> o_beat_valid && $stable(o_beat));

endmodule

`default_nettype wire

// File: hdl/nack_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module nack_fifo import nack_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire nack_rec_t i_rec,
    input  wire            i_push,
    output logic           o_full,
    output nack_rec_t      o_rec,
    output logic           o_valid,
    input  wire            i_pop
);

    nack_rec_t mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;

    assign o_full  = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign o_valid = (count != '0);
    assign o_rec   = mem[rd_ptr];                      // head, shown next cycle after push

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_rec;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;       // wraps at depth
            if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                             // both or neither
            endcase
        end
    end

    // producer and consumer live elsewhere
    a_no_overflow:  assert property (@(posedge clk) disable iff (rst) i_push |-> !o_full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) i_pop |-> o_valid);

endmodule

`default_nettype wire

// File: hdl/nack_gen.sv
`timescale 1ns/1ps
`default_nettype none

module nack_gen import nack_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire dec_req_t  i_dec,
    input  wire            i_dec_valid,
    output logic           o_dec_ready,
    output nack_rec_t      o_rec,
    output logic           o_rec_push,
    input  wire            i_fifo_full,
    input  wire pkt_num_t  i_jump_thresh,
    input  wire flow_sel_t i_rd_flow,
    output pkt_num_t       o_rd_expected,
    output logic           o_resync_pulse
);

    pkt_num_t              exp_tbl [FLOW_CNT];   // expected number per flow
    pkt_num_t              cur_exp;
    pkt_num_t              gap;
    pkt_num_t              win;
    pkt_num_t              next_exp;
    logic [BM_SHIFT_W-1:0] bm_shift;
    logic                  fire;
    logic                  is_data;
    logic                  in_order;
    logic                  late;
    logic                  in_win;

    // ------------------------------------------------------------
    // gap classification, all in the handshake cycle
    assign o_dec_ready = !i_fifo_full;                   // never push into a full fifo
    assign fire        = i_dec_valid && o_dec_ready;
    assign is_data     = fire && (i_dec.typ == REQ_DATA);

    assign cur_exp  = exp_tbl[i_dec.flow];
    assign gap      = i_dec.rpn - cur_exp;               // mod 2^32
    assign next_exp = i_dec.rpn + 1'b1;
    // bitmap caps the window
    assign win      = (i_jump_thresh < pkt_num_t'(BITMAP_W)) ? i_jump_thresh
                                                            : pkt_num_t'(BITMAP_W);

    assign in_order = (gap == '0);
    assign late     = gap[PKT_NUM_W-1];                  // behind expected, dup or late
    assign in_win   = !in_order && !late && (gap <= win);

    // gap ones from bit 0 upward, only meaningful inside the window
    assign bm_shift = BM_SHIFT_W'(BITMAP_W) - gap[BM_SHIFT_W-1:0];

    assign o_rec.info     = i_dec.info;
    assign o_rec.npn      = cur_exp;                     // first missing one
    assign o_rec.bitmap   = {BITMAP_W{1'b1}} >> bm_shift;
    assign o_rec_push     = is_data && in_win;
    assign o_resync_pulse = is_data && !in_order && !late && !in_win;   // jump too big

    assign o_rd_expected = exp_tbl[i_rd_flow];           // csr read port

    // ------------------------------------------------------------
    // table update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < FLOW_CNT; i++) begin
                exp_tbl[i] <= '0;
            end
        end else if (fire) begin
            case (i_dec.typ)
                REQ_DATA: begin
                    if (!late) begin
                        exp_tbl[i_dec.flow] <= next_exp;   // in order, nack or resync
                    end
                end
                REQ_INIT:  exp_tbl[i_dec.flow] <= i_dec.epn;
                REQ_CLOSE: exp_tbl[i_dec.flow] <= '0;
                default:   ;                               // none, consumed only
            endcase
        end
    end

    // upstream register holds its request through a stall
    a_dec_hold: assert property (@(posedge clk) disable iff (rst)
        i_dec_valid && !o_dec_ready |=> i_dec_valid && $stable(i_dec));

endmodule

`default_nettype wire

// File: hdl/nack_pkg.sv
`default_nettype none

package nack_pkg;

    // ------------------------------------------------------------
    // data-path widths
    localparam int FLOW_IDX_W     = 16;                     // flow index in request
    localparam int FLOW_CNT       = 16;                     // on-chip table entries
    localparam int FLOW_SEL_W     = $clog2(FLOW_CNT);       // low index bits used
    localparam int PKT_NUM_W      = 32;
    localparam int INFO_W         = 64;
    localparam int BITMAP_W       = 32;
    localparam int BM_SHIFT_W     = $clog2(BITMAP_W) + 1;   // holds 0..32
    localparam int BEAT_W         = 32;
    localparam int BEATS_PER_NACK = 4;
    localparam int BEAT_IDX_W     = $clog2(BEATS_PER_NACK);
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);

    typedef logic [FLOW_IDX_W-1:0] flow_idx_t;
    typedef logic [FLOW_SEL_W-1:0] flow_sel_t;
    typedef logic [PKT_NUM_W-1:0]  pkt_num_t;
    typedef logic [INFO_W-1:0]     info_t;
    typedef logic [BITMAP_W-1:0]   bitmap_t;
    typedef logic [BEAT_W-1:0]     beat_t;
    typedef logic [BEAT_IDX_W-1:0] beat_idx_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;              // one extra bit for full

    typedef enum logic [1:0] {
        REQ_NONE  = 2'b00,
        REQ_DATA  = 2'b01,
        REQ_INIT  = 2'b10,
        REQ_CLOSE = 2'b11
    } req_type_e;

    // ------------------------------------------------------------
    // request, record and stream records
    typedef struct packed {
        info_t       info;      // per-flow info, passed through
        logic [63:0] exp_num;   // expected number, low half used
        pkt_num_t    rpn;       // received packet number
        logic [7:0]  type_oh;   // one-hot request type
        flow_idx_t   flow_idx;
    } task_req_t;

    typedef struct packed {
        flow_sel_t flow;
        req_type_e typ;
        pkt_num_t  rpn;
        pkt_num_t  epn;
        info_t     info;
    } dec_req_t;

    typedef struct packed {
        info_t    info;
        pkt_num_t npn;          // first missing number
        bitmap_t  bitmap;       // bit i set -> npn+i missing
    } nack_rec_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } nack_beat_t;

endpackage

`default_nettype wire

// File: hdl/nack_top.sv
`timescale 1ns/1ps
`default_nettype none

module nack_top import nack_pkg::*, csr_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire task_req_t  i_req,
    input  wire             i_req_valid,
    output logic            o_req_ready,
    output nack_beat_t      o_nack,
    output logic            o_nack_valid,
    input  wire             i_nack_ready,
    input  wire wb_req_t    i_wb,
    output wb_rsp_t         o_wb
);

    dec_req_t  dec;
    logic      dec_valid;
    logic      dec_ready;
    nack_rec_t gen_rec;
    logic      gen_push;
    logic      fifo_full;
    nack_rec_t fifo_rec;
    logic      fifo_valid;
    logic      fifo_pop;
    pkt_num_t  jump_thresh;
    flow_sel_t rd_flow;
    pkt_num_t  rd_expected;
    logic      resync_pulse;

    task_req_decoder dec_i (.clk(clk), .rst(rst),
        .i_req(i_req), .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
        .o_dec(dec), .o_dec_valid(dec_valid), .i_dec_ready(dec_ready));

    nack_gen gen_i (.clk(clk), .rst(rst),
        .i_dec(dec), .i_dec_valid(dec_valid), .o_dec_ready(dec_ready),
        .o_rec(gen_rec), .o_rec_push(gen_push), .i_fifo_full(fifo_full),
        .i_jump_thresh(jump_thresh), .i_rd_flow(rd_flow), .o_rd_expected(rd_expected),
        .o_resync_pulse(resync_pulse));

    nack_fifo fifo_i (.clk(clk), .rst(rst),
        .i_rec(gen_rec), .i_push(gen_push), .o_full(fifo_full),
        .o_rec(fifo_rec), .o_valid(fifo_valid), .i_pop(fifo_pop));

    nack_deparser dep_i (.clk(clk), .rst(rst),
        .i_rec(fifo_rec), .i_rec_valid(fifo_valid), .o_rec_pop(fifo_pop),
        .o_beat(o_nack), .o_beat_valid(o_nack_valid), .i_beat_ready(i_nack_ready));

    // counters see the external handshakes
    csr_regs csr_i (.clk(clk), .rst(rst), .i_wb(i_wb), .o_wb(o_wb),
        .i_in_fire(i_req_valid && o_req_ready),
        .i_out_last_fire(o_nack_valid && i_nack_ready && o_nack.last),
        .i_resync_pulse(resync_pulse), .o_jump_thresh(jump_thresh),
        .o_rd_flow(rd_flow), .i_rd_expected(rd_expected));

endmodule

`default_nettype wire

// File: hdl/task_req_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module task_req_decoder import nack_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire task_req_t i_req,
    input  wire            i_req_valid,
    output logic           o_req_ready,
    output dec_req_t       o_dec,
    output logic           o_dec_valid,
    input  wire            i_dec_ready
);

    req_type_e req_typ;
    logic      req_fire;

    assign o_req_ready = !o_dec_valid || i_dec_ready;   // refill as stage drains
    assign req_fire    = i_req_valid && o_req_ready;

    // one-hot type reduced by priority, bit 0 wins
    always_comb begin
        if (i_req.type_oh[0])
            req_typ = REQ_DATA;
        else if (i_req.type_oh[1])
            req_typ = REQ_INIT;
        else if (i_req.type_oh[2])
            req_typ = REQ_CLOSE;
        else
            req_typ = REQ_NONE;                         // consumed downstream, no effect
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_dec_valid <= 1'b0;
        end else if (o_req_ready) begin
            o_dec_valid <= i_req_valid;                 // drop valid once taken
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            o_dec.flow <= i_req.flow_idx[FLOW_SEL_W-1:0];   // table covers low bits
            o_dec.typ  <= req_typ;
            o_dec.rpn  <= i_req.rpn;
            o_dec.epn  <= i_req.exp_num[PKT_NUM_W-1:0];
            o_dec.info <= i_req.info;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_nack_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nack_top import nack_pkg::*, csr_pkg::*; ();

    localparam int NUM_TESTS  = 6;
    localparam int TIMEOUT_NS = NUM_TESTS * 2000;   // per-test budget

    logic       clk = 1'b0;
    logic       rst;
    task_req_t  i_req;
    logic       i_req_valid;
    logic       o_req_ready;
    nack_beat_t o_nack;
    logic       o_nack_valid;
    logic       i_nack_ready;
    wb_req_t    i_wb;
    wb_rsp_t    o_wb;

    logic [31:0] rng_state = 32'd39640;
    pkt_num_t    model_exp [FLOW_CNT];                  // reference table
    pkt_num_t    cur_thresh;
    nack_rec_t   exp_q [$];                             // frames still owed
    nack_beat_t  beat_q [$];                            // beats seen on the stream
    int          errors;
    int          checks;
    int          n_req;
    int          n_frames;
    int          model_resyncs;

    nack_top dut_i (.clk(clk), .rst(rst), .i_req(i_req), .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready), .o_nack(o_nack), .o_nack_valid(o_nack_valid),
        .i_nack_ready(i_nack_ready), .i_wb(i_wb), .o_wb(o_wb));

    always #5 clk = ~clk;

    // stream sink, sampled on the completing edge
    always @(posedge clk) begin
        if (!rst && o_nack_valid && i_nack_ready) begin
            beat_q.push_back(o_nack);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

    // ------------------------------------------------------------
    // helpers
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;                   // xorshift32
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // generator's data rule, gap = received - expected
    function automatic void model_data(input flow_sel_t flow, input pkt_num_t rpn,
                                       input info_t info);
        pkt_num_t  gap;
        pkt_num_t  lim;
        nack_rec_t rec;
        gap = rpn - model_exp[flow];
        lim = (cur_thresh < 32'd32) ? cur_thresh : 32'd32;   // bitmap limit
        if (gap[31]) return;                            // late or duplicate
        if (gap != '0 && gap <= lim) begin
            rec.npn    = model_exp[flow];
            rec.info   = info;
            rec.bitmap = '0;
            for (int i = 0; i < BITMAP_W; i++) begin
                if (pkt_num_t'(i) < gap) rec.bitmap[i] = 1'b1;
            end
            exp_q.push_back(rec);
            n_frames++;                                 // one frame owed
        end else if (gap != '0) begin
            model_resyncs++;                            // jump too big
        end
        model_exp[flow] = rpn + 32'd1;
    endfunction

    // call on a falling edge, returns on the falling edge after the transfer
    task automatic send_req(input flow_sel_t flow, input logic [7:0] type_oh,
                            input pkt_num_t rpn, input logic [63:0] exp_num, input info_t info);
        i_req.flow_idx = {12'hA5C, flow};               // upper bits unused by table
        i_req.type_oh  = type_oh;
        i_req.rpn      = rpn;
        i_req.exp_num  = exp_num;
        i_req.info     = info;
        i_req_valid    = 1'b1;
        while (!o_req_ready) @(negedge clk);
        @(negedge clk);
        i_req_valid = 1'b0;
        n_req++;
    endtask

    task automatic send_data(input flow_sel_t flow, input pkt_num_t rpn);
        info_t info;
        info = {next_rand(), next_rand()};
        model_data(flow, rpn, info);
        send_req(flow, 8'h05, rpn, {next_rand(), next_rand()}, info);   // bit 0 beats close
    endtask

    task automatic send_init(input flow_sel_t flow, input pkt_num_t base);
        model_exp[flow] = base;
        send_req(flow, 8'h06, next_rand(), {next_rand(), base}, {next_rand(), next_rand()});
    endtask

    task automatic wb_write(input csr_addr_t waddr, input csr_data_t wdat);
        i_wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, addr: waddr, dat: wdat};
        @(negedge clk);
        while (!o_wb.ack) @(negedge clk);
        i_wb = '0;
    endtask

    task automatic wb_read(input csr_addr_t raddr, output csr_data_t rdat);
        i_wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: raddr, dat: '0};
        @(negedge clk);
        while (!o_wb.ack) @(negedge clk);
        rdat = o_wb.dat;                                // valid with ack
        i_wb = '0;
    endtask

    task automatic read_expect(input string name, input csr_addr_t raddr, input csr_data_t exp);
        csr_data_t rdat;
        wb_read(raddr, rdat);
        check(name, rdat, exp);
    endtask

    function automatic csr_addr_t flow_addr(input flow_sel_t flow);
        return ADDR_FLOW_BASE + {2'b00, flow, 2'b00};
    endfunction

    task automatic settle();
        repeat (8) @(negedge clk);                      // longer than request to first beat
    endtask

    task automatic expect_frame();
        nack_rec_t  rec;
        nack_beat_t b [4];
        while (beat_q.size() < 4) @(negedge clk);
        rec = exp_q.pop_front();
        for (int i = 0; i < 4; i++) b[i] = beat_q.pop_front();
        check("beat0 npn", b[0].data, rec.npn);
        check("beat1 bitmap", b[1].data, rec.bitmap);
        check("beat2 info hi", b[2].data, rec.info[63:32]);
        check("beat3 info lo", b[3].data, rec.info[31:0]);
        for (int i = 0; i < 4; i++) check($sformatf("beat%0d last", i), b[i].last, i == 3);
    endtask

    // ------------------------------------------------------------
    // directed tests
    task automatic reg_access();
        csr_data_t val;
        check("o_req_ready", o_req_ready, 1'b1);          // idle handshakes out of reset
        check("o_nack_valid", o_nack_valid, 1'b0);
        check("o_wb.ack", o_wb.ack, 1'b0);
        read_expect("scratch", ADDR_SCRATCH, SCRATCH_RESET);
        read_expect("jump_thresh", ADDR_JUMP_THRESH, JUMP_THRESH_RESET);
        read_expect("in_count", ADDR_IN_COUNT, '0);
        read_expect("out_count", ADDR_OUT_COUNT, '0);
        read_expect("resync_count", ADDR_RESYNC_COUNT, '0);
        read_expect("flow0 expected", flow_addr(4'd0), '0);
        val = next_rand();
        wb_write(ADDR_SCRATCH, val);
        read_expect("scratch", ADDR_SCRATCH, val);
        wb_write(ADDR_JUMP_THRESH, 32'd7);
        read_expect("jump_thresh", ADDR_JUMP_THRESH, 32'd7);
        wb_write(ADDR_JUMP_THRESH, JUMP_THRESH_RESET);
        wb_write(ADDR_IN_COUNT, 32'h1234);              // read-only, ignored
        read_expect("in_count", ADDR_IN_COUNT, '0);
        read_expect("unmapped", 8'h30, '0);
    endtask

    task automatic gap_nack();
        pkt_num_t base;
        base = next_rand();
        send_init(4'd1, base);
        send_data(4'd1, base);
        send_data(4'd1, base + 32'd5);                  // four missing
        expect_frame();
        read_expect("flow1 expected", flow_addr(4'd1), base + 32'd6);
    endtask

    task automatic in_order_late();
        pkt_num_t base;
        base = next_rand();
        send_init(4'd2, base);
        for (int i = 0; i < 3; i++) send_data(4'd2, base + pkt_num_t'(i));
        send_data(4'd2, base + 32'd1);                  // duplicate
        settle();
        check("in-order beats", beat_q.size(), 0);
        read_expect("flow2 expected", flow_addr(4'd2), model_exp[2]);
    endtask

    task automatic jump_resync();
        pkt_num_t base;
        wb_write(ADDR_JUMP_THRESH, 32'd3);
        cur_thresh = 32'd3;
        base = next_rand();
        send_init(4'd3, base);
        send_data(4'd3, base);
        send_data(4'd3, base + 32'd11);                 // gap of 10
        settle();
        check("resync beats", beat_q.size(), 0);
        read_expect("resync_count", ADDR_RESYNC_COUNT, model_resyncs);
        read_expect("flow3 expected", flow_addr(4'd3), base + 32'd12);
        wb_write(ADDR_JUMP_THRESH, JUMP_THRESH_RESET);
        cur_thresh = JUMP_THRESH_RESET;
    endtask

    task automatic back_pressure();
        flow_sel_t f;
        int        n;
        i_nack_ready = 1'b0;
        for (int i = 4; i < 8; i++) send_init(flow_sel_t'(i), next_rand());
        n = 0;
        while (o_req_ready && n < 20) begin
            f = flow_sel_t'(4 + n % 4);
            send_data(f, model_exp[f] + 32'd2);
            n++;
        end
        if (o_req_ready) begin
            errors++;
            $display("request ready never fell while the stream was held off");
        end
        i_nack_ready = 1'b1;
        while (exp_q.size() > 0) expect_frame();        // request order
    endtask

    task automatic counter_clear();
        read_expect("in_count", ADDR_IN_COUNT, n_req);
        read_expect("out_count", ADDR_OUT_COUNT, n_frames);
        read_expect("resync_count", ADDR_RESYNC_COUNT, model_resyncs);
        wb_write(ADDR_CLEAR, 32'd1);
        read_expect("clear", ADDR_CLEAR, '0);           // self-clearing
        read_expect("in_count", ADDR_IN_COUNT, '0);
        read_expect("out_count", ADDR_OUT_COUNT, '0);
        read_expect("resync_count", ADDR_RESYNC_COUNT, '0);
    endtask

    initial begin
        rst          = 1'b1;
        i_req        = '0;
        i_req_valid  = 1'b0;
        i_nack_ready = 1'b1;
        i_wb         = '0;
        errors       = 0;
        checks       = 0;
        n_req        = 0;
        n_frames     = 0;
        cur_thresh   = JUMP_THRESH_RESET;
        model_resyncs = 0;
        for (int i = 0; i < FLOW_CNT; i++) model_exp[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reg_access();
        gap_nack();
        in_order_late();
        jump_resync();
        back_pressure();
        counter_clear();
        check("leftover beats", beat_q.size(), 0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/nack_pkg.sv
hdl/csr_pkg.sv
hdl/task_req_decoder.sv
hdl/nack_gen.sv
hdl/nack_fifo.sv
hdl/nack_deparser.sv
hdl/csr_regs.sv
hdl/nack_top.sv
tb/tb_nack_top.sv
